/* Makefile */
# Verilator flow for the clock controller

VERILATOR ?= verilator
TOP       ?= tb_clock_ctrl
SEED      ?= 62637
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_MSG  := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) \
	  --top-module $(TOP) -GSEED=$(SEED)

sim:
	$(VERILATOR) --binary --timing -j 0 $(VFLAGS) -f $(FILELIST) \
	  --top-module $(TOP) -GSEED=$(SEED) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
hdl/clock_ctrl_pkg.sv
hdl/phaser.sv
hdl/global_reset_gen.sv
hdl/clock_activity_monitor.sv
hdl/clock_ctrl.sv
dv/phase_shift_model.sv
dv/tb_clock_ctrl.sv

/* dv/phase_shift_model.sv */
`timescale 1ns/1ps

module phase_shift_model #(
  parameter int SEED = 62637  // Seed of the psdone delay draw
) (
  input  logic clock,      // Main clock
  input  logic mgr_reset,  // Clock manager held in reset
  input  logic psen,       // Step request
  input  logic psincdec,   // 1 = increment
  output logic psdone,     // Step finished
  output int   position,   // Signed fine position
  output int   overlaps    // Requests seen with a step pending
);

  int   seed = SEED;        // Running $random state
  int   countdown = 0;      // Cycles left to psdone
  int   overlap_count = 0;  // Sticky across manager resets
  logic pending = 1'b0;     // Step in flight

  // --------------------
  // Phase-shift port
  // --------------------
  always @(posedge clock) begin
    psdone <= 1'b0;
    if (mgr_reset) begin
      position  <= 0;       // Manager restarts at zero shift
      pending   <= 1'b0;
      countdown <= 0;
    end else if (psen) begin
      if (pending) begin
        overlap_count <= overlap_count + 1;  // Second psen before psdone
      end
      position  <= psincdec ? position + 1 : position - 1;
      pending   <= 1'b1;
      countdown <= 1 + int'($unsigned($random(seed)) % 8);  // 1..8 cycles
    end else if (pending) begin
      if (countdown <= 1) begin
        psdone  <= 1'b1;    // One-cycle pulse
        pending <= 1'b0;
      end
      countdown <= countdown - 1;
    end
  end

  assign overlaps = overlap_count;

endmodule

/* dv/tb_clock_ctrl.sv */
`timescale 1ns/1ps

module tb_clock_ctrl #(
  parameter int SEED = 62637  // Base seed of the psdone delays
);

  import clock_ctrl_pkg::*;

  localparam int NUM_DPS     = 4;
  localparam int NUM_ROWS    = 10;
  localparam int STEP_LIMIT  = DPS_STEPS_PER_CYCLE * 11 + 50;  // Cycles for a full walk
  localparam int WATCHDOG_NS = (NUM_ROWS + 4) * DPS_STEPS_PER_CYCLE * 11 * 4 + 20000;

  logic                            clock;
  logic                            rst;
  logic                            lock_main;
  logic                            global_reset_en;
  logic [NUM_DPS-1:0]              dps_lock;
  logic [NUM_DPS-1:0]              dps_fire;
  logic [NUM_DPS-1:0]              dps_reset;
  logic [NUM_DPS*DPS_PHASE_W-1:0]  dps_phase;
  wire  [NUM_DPS-1:0]              dps_psdone;    // From the models
  logic [NUM_DPS-1:0]              dps_psen;
  logic [NUM_DPS-1:0]              dps_psincdec;
  logic [NUM_DPS-1:0]              dps_busy;
  logic [NUM_DPS*DPS_SM_W-1:0]     dps_sm_vec;
  logic                            global_reset;
  logic                            clock_lock_lost_err;
  logic [NUM_MONITORED-1:0]        mon_clocks;
  logic [NUM_MONITORED-1:0]        mon_lock;
  logic [NUM_MONITORED-1:0]        run_mask;      // 1 = input toggles
  logic [NUM_MONITORED-1:0]        stuck_val;     // Level of stuck inputs
  logic                            clk_delayed;
  int                              model_pos [NUM_DPS];
  int                              overlaps [NUM_DPS];
  int                              errors = 0;
  int                              tests_passed = 0;
  int                              tests_failed = 0;

  // Channel, coarse phase, reset first, expected fine step
  typedef struct packed {
    logic [1:0]  ch;
    logic [7:0]  phase;
    logic        reset_first;
    logic [10:0] expect_pos;
  } row_t;

  row_t rows [NUM_ROWS] = '{
    '{2'd0, 8'd128, 1'b0, 11'd700},   // Up from zero
    '{2'd0, 8'd255, 1'b0, 11'd1395},  // Top of range
    '{2'd0, 8'd0,   1'b0, 11'd0},     // All the way down
    '{2'd1, 8'd16,  1'b0, 11'd88},    // 87.5 rounds up
    '{2'd1, 8'd1,   1'b0, 11'd5},
    '{2'd2, 8'd200, 1'b0, 11'd1094},
    '{2'd2, 8'd48,  1'b1, 11'd263},   // Reset, then 262.5 up
    '{2'd3, 8'd100, 1'b0, 11'd547},
    '{2'd3, 8'd37,  1'b0, 11'd202},   // Down
    '{2'd1, 8'd160, 1'b1, 11'd875}    // Reset, then up
  };

  // --------------------
  // Clock and sources
  // --------------------
  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;  // 4 ns period
  end

  assign #1 clk_delayed = clock;
  assign mon_clocks = (run_mask & {NUM_MONITORED{clk_delayed}}) | (~run_mask & stuck_val);

  clock_ctrl #(.NUM_DPS(NUM_DPS)) dut (
    .clock(clock), .rst(rst), .lock_main(lock_main), .global_reset_en(global_reset_en),
    .dps_lock(dps_lock), .dps_fire(dps_fire), .dps_reset(dps_reset),
    .dps_phase(dps_phase), .dps_psdone(dps_psdone), .dps_psen(dps_psen),
    .dps_psincdec(dps_psincdec), .dps_busy(dps_busy), .dps_sm_vec(dps_sm_vec),
    .global_reset(global_reset), .clock_lock_lost_err(clock_lock_lost_err),
    .mon_clocks(mon_clocks), .mon_lock(mon_lock)
  );

  for (genvar i = 0; i < NUM_DPS; i++) begin : g_model
    phase_shift_model #(.SEED(SEED + i)) u_model (
      .clock(clock), .mgr_reset(dps_reset[i] || !lock_main),
      .psen(dps_psen[i]), .psincdec(dps_psincdec[i]), .psdone(dps_psdone[i]),
      .position(model_pos[i]), .overlaps(overlaps[i])
    );
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic next_cycle();
    @(posedge clock);
    #1;  // Past the edge, outputs settled
  endtask

  task automatic check_that(input bit ok, input string what);
    assert (ok) else begin
      errors++;
      $display("ERROR %0t ns: %s", $time, what);
    end
  endtask

  task automatic check_position(input int ch, input int exp_pos);
    check_that(model_pos[ch] == exp_pos,
      $sformatf("channel %0d position %0d, expected %0d", ch, model_pos[ch], exp_pos));
    check_that(overlaps[ch] == 0,
      $sformatf("channel %0d issued psen %0d times before psdone", ch, overlaps[ch]));
  endtask

  task automatic wait_idle(input int ch, input string what);
    int n;
    n = 0;
    while (dps_busy[ch] && n < STEP_LIMIT) begin
      next_cycle();
      n++;
    end
    assert (!dps_busy[ch]) else begin
      errors++;
      $display("Channel %0d never went idle during %s", ch, what);
    end
  endtask

  task automatic load_fire(input int ch, input logic [7:0] phase);
    dps_phase[ch*DPS_PHASE_W +: DPS_PHASE_W] <= phase;
    dps_fire[ch] <= 1'b1;
  endtask

  task automatic end_fire();
    @(posedge clock);
    dps_fire <= '0;  // One-cycle pulse
    #1;
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("[PASS] %s", name);
    end else begin
      tests_failed++;
      $display("[FAIL] %s, %0d failed checks", name, errors - errors_before);
    end
  endtask

  // --------------------
  // Watchdog
  // --------------------
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run timed out", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
  end

  // --------------------
  // Stimulus and checks
  // --------------------
  initial begin
    int start;
    int ch;
    logic [NUM_MONITORED-1:0] mask;
    rst             <= 1'b1;
    lock_main       <= 1'b0;
    global_reset_en <= 1'b1;
    dps_lock        <= '0;
    dps_fire        <= '0;
    dps_reset       <= '0;
    dps_phase       <= '0;
    run_mask        <= '0;
    stuck_val       <= '0;

    start = errors;
    repeat (8) @(posedge clock);
    rst <= 1'b0;
    next_cycle();
    check_that(global_reset === 1'b1, "global_reset low after reset");
    check_that(dps_busy === '1, $sformatf("busy %b after reset", dps_busy));
    check_that(dps_psen === '0, $sformatf("psen %b after reset", dps_psen));
    @(posedge clock);
    lock_main <= 1'b1;
    next_cycle();
    check_that(global_reset === 1'b0, "global_reset still high after lock_main");
    repeat (2) next_cycle();  // Hold gone but no channel lock yet
    check_that(dps_busy === '1, "busy fell before dps_lock");
    @(posedge clock);
    dps_lock <= '1;
    for (int i = 0; i < NUM_DPS; i++) begin
      wait_idle(i, "startup");
      check_position(i, 0);
    end
    finish_test("reset and startup", start);

    for (int r = 0; r < NUM_ROWS; r++) begin
      start = errors;
      ch = int'(rows[r].ch);
      if (rows[r].reset_first) begin
        @(posedge clock);
        dps_reset[ch] <= 1'b1;
        @(posedge clock);
        dps_reset[ch] <= 1'b0;
        #1;
        check_that(dps_busy[ch] === 1'b1, $sformatf("channel %0d idle during reset", ch));
        check_that(dps_sm_vec[ch*DPS_SM_W +: DPS_SM_W] === ps_wait_lock,
          $sformatf("channel %0d state %0d during reset", ch,
            dps_sm_vec[ch*DPS_SM_W +: DPS_SM_W]));
        wait_idle(ch, "reset recovery");
      end
      @(posedge clock);
      load_fire(ch, rows[r].phase);
      end_fire();
      wait_idle(ch, "phase walk");
      check_position(ch, int'(rows[r].expect_pos));
      check_that(dps_psen[ch] === 1'b0, $sformatf("channel %0d psen high when idle", ch));
      check_that(dps_sm_vec[ch*DPS_SM_W +: DPS_SM_W] === ps_idle,
        $sformatf("channel %0d state %0d when idle", ch,
          dps_sm_vec[ch*DPS_SM_W +: DPS_SM_W]));
      finish_test($sformatf("row %0d channel %0d phase %0d", r, ch, rows[r].phase), start);
    end

    // Second fire lands while the first walk is running
    start = errors;
    @(posedge clock);
    load_fire(0, 8'd255);
    end_fire();
    repeat (4) next_cycle();
    check_that(dps_busy[0] === 1'b1, "channel 0 not busy during walk");
    @(posedge clock);
    load_fire(0, 8'd64);
    end_fire();
    wait_idle(0, "fire while busy");
    check_position(0, 1395);
    finish_test("fire while busy is ignored", start);

    // Two channels walking together
    start = errors;
    @(posedge clock);
    load_fire(2, 8'd10);
    load_fire(3, 8'd240);
    end_fire();
    wait_idle(2, "dual walk");
    wait_idle(3, "dual walk");
    check_position(2, 55);
    check_position(3, 1313);  // 1312.5 rounds up
    finish_test("two channels at once", start);

    start = errors;
    @(posedge clock);
    lock_main <= 1'b0;  // Re-fire enabled
    next_cycle();
    check_that(global_reset === 1'b1, "global_reset not re-fired on lock loss");
    check_that(clock_lock_lost_err === 1'b0, "lock_lost_err high with reset re-fired");
    check_that(dps_busy === '1, $sformatf("busy %b with lock lost", dps_busy));
    @(posedge clock);
    lock_main <= 1'b1;
    next_cycle();
    check_that(global_reset === 1'b0, "global_reset stuck after relock");
    for (int i = 0; i < NUM_DPS; i++) begin
      wait_idle(i, "relock");
      check_position(i, 0);
    end
    @(posedge clock);
    load_fire(3, 8'd64);
    end_fire();
    wait_idle(3, "walk after relock");
    check_position(3, 350);  // Walk starts at zero again
    finish_test("lock loss with re-fire", start);

    start = errors;
    @(posedge clock);
    global_reset_en <= 1'b0;
    lock_main       <= 1'b0;
    next_cycle();
    check_that(global_reset === 1'b0, "global_reset re-fired while disabled");
    check_that(clock_lock_lost_err === 1'b1, "lock_lost_err low with lock lost");
    @(posedge clock);
    lock_main       <= 1'b1;
    global_reset_en <= 1'b1;
    next_cycle();
    check_that(clock_lock_lost_err === 1'b0, "lock_lost_err stuck after relock");
    for (int i = 0; i < NUM_DPS; i++) begin
      wait_idle(i, "relock");
    end
    finish_test("lock loss without re-fire", start);

    for (int p = 0; p < 2; p++) begin
      start = errors;
      mask = (p == 0) ? 7'b1010011 : 7'b0101100;
      @(posedge clock);
      run_mask  <= mask;
      stuck_val <= 7'b0110101;  // Mix of stuck high and low
      next_cycle();
      check_that(mon_lock === mask, $sformatf("mon_lock %b, expected %b", mon_lock, mask));
      finish_test($sformatf("activity pattern %0d", p), start);
    end

    $display("Tests passed: %0d, failed: %0d, failed checks: %0d",
      tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* hdl/clock_activity_monitor.sv */
`timescale 1ns/1ps

module clock_activity_monitor #(
  parameter int NUM_CLK = clock_ctrl_pkg::NUM_MONITORED  // Inputs to watch
) (
  input  logic               clock,       // Main 40 MHz clock
  input  logic               rst,         // Sync reset
  input  logic [NUM_CLK-1:0] mon_clocks,  // Unused clock inputs
  output logic [NUM_CLK-1:0] mon_lock     // Pseudo-lock per input
);

  // --------------------
  // Dual-edge samples
  // --------------------
  logic [NUM_CLK-1:0] rise_q;  // Sampled on posedge
  logic [NUM_CLK-1:0] fall_q;  // Sampled on negedge

  always_ff @(posedge clock) begin
    if (rst) begin
      rise_q <= '0;
    end else begin
      rise_q <= mon_clocks;
    end
  end

  // Same reset level seen half a cycle later
  always_ff @(negedge clock) begin
    if (rst) begin
      fall_q <= '0;
    end else begin
      fall_q <= mon_clocks;
    end
  end

  // --------------------
  // Pseudo-lock
  // --------------------
  // A running clock of the same rate is caught high on one edge and low
  // on the other, so the two samples differ. A stuck input gives equal samples
  assign mon_lock = rise_q ^ fall_q;

endmodule

/* hdl/clock_ctrl.sv */
`timescale 1ns/1ps

module clock_ctrl #(
  parameter int NUM_DPS = 4  // Phaser channels, 1..9
) (
  input  logic                                          clock,            // Main 40 MHz clock
  input  logic                                          rst,              // Sync reset
  input  logic                                          lock_main,        // Main manager lock
  input  logic                                          global_reset_en,  // Re-fire enable

  // Phaser bus and clock-manager ports
  input  logic [NUM_DPS-1:0]                            dps_lock,      // Channel locks
  input  logic [NUM_DPS-1:0]                            dps_fire,      // Set new phase
  input  logic [NUM_DPS-1:0]                            dps_reset,     // Reset channel phase
  input  logic [NUM_DPS*clock_ctrl_pkg::DPS_PHASE_W-1:0] dps_phase,    // Coarse phases
  input  logic [NUM_DPS-1:0]                            dps_psdone,    // Step done
  output logic [NUM_DPS-1:0]                            dps_psen,      // Step enable
  output logic [NUM_DPS-1:0]                            dps_psincdec,  // Step direction
  output logic [NUM_DPS-1:0]                            dps_busy,      // Channel busy
  output logic [NUM_DPS*clock_ctrl_pkg::DPS_SM_W-1:0]    dps_sm_vec,   // State codes

  // Global reset
  output logic                                          global_reset,         // FPGA-wide
  output logic                                          clock_lock_lost_err,  // Lock lost

  // Unused clock monitor
  input  logic [clock_ctrl_pkg::NUM_MONITORED-1:0]       mon_clocks,  // Raw inputs
  output logic [clock_ctrl_pkg::NUM_MONITORED-1:0]       mon_lock     // Pseudo-locks
);

  import clock_ctrl_pkg::*;

  // --------------------
  // Phaser channels
  // --------------------
  for (genvar i = 0; i < NUM_DPS; i++) begin : g_dps
    phaser u_phaser (
      .clock        (clock),
      .rst          (rst),
      .global_reset (global_reset),      // Fed back from the generator
      .lock_main    (lock_main),
      .lock_dcm     (dps_lock[i]),
      .fire         (dps_fire[i]),
      .reset        (dps_reset[i]),
      .phase        (dps_phase[i*DPS_PHASE_W +: DPS_PHASE_W]),  // Channel slice
      .psdone       (dps_psdone[i]),
      .psen         (dps_psen[i]),
      .psincdec     (dps_psincdec[i]),
      .busy         (dps_busy[i]),
      .sm_vec       (dps_sm_vec[i*DPS_SM_W +: DPS_SM_W])        // Channel slice
    );
  end

  // --------------------
  // Global reset
  // --------------------
  global_reset_gen u_global_reset_gen (
    .clock           (clock),
    .rst             (rst),
    .lock_main       (lock_main),
    .global_reset_en (global_reset_en),
    .global_reset    (global_reset),
    .lock_lost_err   (clock_lock_lost_err)
  );

  // --------------------
  // Activity monitor
  // --------------------
  clock_activity_monitor #(
    .NUM_CLK (NUM_MONITORED)  // All seven unused inputs
  ) u_clock_activity_monitor (
    .clock      (clock),
    .rst        (rst),
    .mon_clocks (mon_clocks),
    .mon_lock   (mon_lock)
  );

endmodule

/* hdl/clock_ctrl_pkg.sv */
package clock_ctrl_pkg;

  // --------------------
  // Widths and counts
  // --------------------
  localparam int DPS_PHASE_W         = 8;     // Bus phase request, 256 coarse steps
  localparam int DPS_STEP_W          = 11;    // Fine position, holds 0..1399
  localparam int DPS_STEPS_PER_CYCLE = 1400;  // Fine steps in one 25 ns cycle
  localparam int DPS_SM_W            = 3;     // State code width
  localparam int NUM_MONITORED       = 7;     // Unused clock inputs under watch

  // --------------------
  // Phaser FSM states
  // --------------------
  typedef enum logic [DPS_SM_W-1:0] {
    ps_wait_lock = 3'd0,  // Held until main and channel locks
    ps_idle      = 3'd1,  // Parked, ready for fire
    ps_compare   = 3'd2,  // Position vs target
    ps_step      = 3'd3,  // psen cycle
    ps_wait_done = 3'd4   // Waiting on psdone
  } phaser_state_e;

  // --------------------
  // Coarse to fine step mapping
  // --------------------
  // p*1400/256 rounded to nearest, halves go up.
  // Done as (2*p*1400 + 256) / 512 so it stays in integers
  function automatic logic [DPS_STEP_W-1:0] steps_for_phase(
    input logic [DPS_PHASE_W-1:0] p
  );
    int num;
    int den;
    int q;
    num = int'(p) * 2 * DPS_STEPS_PER_CYCLE + (1 << DPS_PHASE_W);  // Scaled plus half
    den = 1 << (DPS_PHASE_W + 1);                                   // 2 * 256
    q   = num / den;                                                // Truncates
    return q[DPS_STEP_W-1:0];
  endfunction

endpackage

/* hdl/global_reset_gen.sv */
`timescale 1ns/1ps

module global_reset_gen (
  input  logic clock,            // Main 40 MHz clock
  input  logic rst,              // Sync reset
  input  logic lock_main,        // Main clock manager lock
  input  logic global_reset_en,  // Re-fire on lock loss
  output logic global_reset,     // FPGA-wide reset, registered
  output logic lock_lost_err     // Lock gone after startup
);

  logic startup_done;  // Seen first lock
  logic first_lock;    // Lock now or earlier

  assign first_lock = lock_main || startup_done;

  // --------------------
  // Startup and re-fire
  // --------------------
  always_ff @(posedge clock) begin
    if (rst) begin
      startup_done <= 1'b0;
      global_reset <= 1'b1;      // Held until first lock
    end else begin
      startup_done <= first_lock;  // Sticky until rst
      global_reset <= !first_lock || (!lock_main && global_reset_en);
    end
  end

  // Lock dropped but reset not re-fired
  assign lock_lost_err = !global_reset && !lock_main;

endmodule

/* hdl/phaser.sv */
`timescale 1ns/1ps

module phaser (
  input  logic                                clock,         // Main 40 MHz clock
  input  logic                                rst,           // Sync reset
  input  logic                                global_reset,  // Held until main lock
  input  logic                                lock_main,     // Main clock manager lock
  input  logic                                lock_dcm,      // This channel's lock
  input  logic                                fire,          // Bus pulse, new phase
  input  logic                                reset,         // Bus reset of this channel
  input  logic [clock_ctrl_pkg::DPS_PHASE_W-1:0] phase,     // Coarse phase 0..255
  input  logic                                psdone,        // Step finished
  output logic                                psen,          // Step request, one cycle
  output logic                                psincdec,      // 1 = increment
  output logic                                busy,          // Channel not parked
  output logic [clock_ctrl_pkg::DPS_SM_W-1:0]    sm_vec     // Encoded state
);

  import clock_ctrl_pkg::*;

  localparam int TABLE_DEPTH = 1 << DPS_PHASE_W;  // One entry per coarse phase

  // --------------------
  // Step table
  // --------------------
  logic [DPS_STEP_W-1:0] step_table [TABLE_DEPTH];  // Coarse to fine, constant

  for (genvar a = 0; a < TABLE_DEPTH; a++) begin : g_table
    assign step_table[a] = steps_for_phase(DPS_PHASE_W'(a));
  end

  // --------------------
  // Walking FSM
  // --------------------
  phaser_state_e         state;     // Current state
  logic [DPS_STEP_W-1:0] target;    // Latched fine target
  logic [DPS_STEP_W-1:0] position;  // Fine steps applied so far
  logic                  hold;      // Clock manager held in reset

  // Any of these resets the real clock manager, so phase is back at zero
  assign hold = rst || global_reset || !lock_main || reset;

  always_ff @(posedge clock) begin
    if (hold) begin
      state    <= ps_wait_lock;
      position <= '0;           // Manager restarts at zero shift
      psen     <= 1'b0;
      psincdec <= 1'b0;
    end else begin
      psen <= 1'b0;             // Only ever a single-cycle pulse
      case (state)
        ps_wait_lock: begin
          if (lock_dcm) begin
            state <= ps_idle;   // Main lock already implied by !hold
          end
        end

        ps_idle: begin
          if (fire) begin
            state <= ps_compare;  // Leaves idle one cycle after fire
          end
        end

        ps_compare: begin
          if (target > position) begin
            psen     <= 1'b1;   // Walk up
            psincdec <= 1'b1;
            state    <= ps_step;
          end else if (target < position) begin
            psen     <= 1'b1;   // Walk down
            psincdec <= 1'b0;
            state    <= ps_step;
          end else begin
            state <= ps_idle;   // Arrived, busy drops
          end
        end

        ps_step: begin
          state <= ps_wait_done;  // psen high during this cycle
        end

        ps_wait_done: begin
          if (psdone) begin       // Back-pressure, wait as long as needed
            if (psincdec) begin
              position <= position + 1'b1;
            end else begin
              position <= position - 1'b1;
            end
            state <= ps_compare;
          end
        end

        default: begin
          state <= ps_wait_lock;  // Unused codes recover
        end
      endcase
    end
  end

  // Target latched on an accepted fire
  always_ff @(posedge clock) begin
    if (state == ps_idle && fire) begin
      target <= step_table[phase];
    end
  end

  // --------------------
  // Status
  // --------------------
  assign busy   = (state != ps_idle);  // High in wait_lock too
  assign sm_vec = state;

endmodule
